/* verilog/wr16_cfg.svh */
`ifndef WR16_CFG_SVH
`define WR16_CFG_SVH

// Datapath and instruction widths
`define WR16_DATA_W    32
`define WR16_ADDR_W    32
`define WR16_INST_W    16
`define WR16_NUM_REGS  16
`define WR16_REG_AW    4

// Opcode field encodings, anything unlisted runs as NOP
`define WR16_OP_NOP    4'd0
`define WR16_OP_LDI    4'd1
`define WR16_OP_ADD    4'd2
`define WR16_OP_SUB    4'd3
`define WR16_OP_AND    4'd4
`define WR16_OP_OR     4'd5
`define WR16_OP_XOR    4'd6
`define WR16_OP_LD     4'd7
`define WR16_OP_ST     4'd8

`endif

/* verilog/wr16_pkg.sv */
`default_nettype none

`include "wr16_cfg.svh"

package wr16_pkg;

  typedef logic [`WR16_DATA_W-1:0] word_t;
  typedef logic [`WR16_ADDR_W-1:0] addr_t;
  typedef logic [`WR16_INST_W-1:0] inst_t;
  typedef logic [`WR16_REG_AW-1:0] reg_addr_t;

  typedef enum logic [2:0] {
    ALU_PASS_B,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  typedef enum logic {
    FETCH_REQ,
    FETCH_HOLD
  } fetch_state_e;

  // Control word leaving decode
  typedef struct packed {
    alu_op_e   alu_op;
    logic      use_lit;
    logic [7:0] literal;
    reg_addr_t rd;
    reg_addr_t rn;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
  } decoded_t;

  // Work handed from execute to the memory stage
  typedef struct packed {
    word_t     alu_result;
    word_t     store_data;
    addr_t     addr;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    reg_addr_t rd;
  } mem_req_t;

  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    word_t     data;
  } reg_write_t;

endpackage

`default_nettype wire

/* verilog/wr16_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module wr16_fetch (
  input  wire             core_clk,
  input  wire             rst_n_i,
  input  wr16_pkg::inst_t inst_data_i,
  input  wire             inst_valid_i,
  input  wire             dec_ready_i,
  output wr16_pkg::addr_t inst_addr_o,
  output logic            inst_valid_o,
  output wr16_pkg::inst_t fetch_inst_o,
  output logic            fetch_valid_o
);

  import wr16_pkg::*;

  fetch_state_e state_q;
  addr_t        pc_q;
  inst_t        inst_q;
  logic         req_q;

  // Request is a registered level so it stays low through reset
  assign inst_valid_o  = req_q;
  assign inst_addr_o   = pc_q;
  assign fetch_inst_o  = inst_q;
  assign fetch_valid_o = (state_q == FETCH_HOLD);

  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= FETCH_REQ;
      req_q   <= 1'b0;
      pc_q    <= '0;
    end
    else if (state_q == FETCH_REQ)
    begin
      if (req_q && inst_valid_i)
      begin
        state_q <= FETCH_HOLD;
        req_q   <= 1'b0;
      end
      else
      begin
        req_q <= 1'b1;
      end
    end
    else if (dec_ready_i)
    begin
      // Decode took it, move on to the next word
      state_q <= FETCH_REQ;
      req_q   <= 1'b1;
      pc_q    <= pc_q + 1'b1;
    end
  end

  // Instruction word, captured on the completing cycle
  always_ff @(posedge core_clk)
  begin
    if (state_q == FETCH_REQ && req_q && inst_valid_i)
    begin
      inst_q <= inst_data_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/wr16_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wr16_cfg.svh"

module wr16_decode (
  input  wire                  core_clk,
  input  wire                  rst_n_i,
  input  wr16_pkg::inst_t      fetch_inst_i,
  input  wire                  fetch_valid_i,
  input  wire                  ex_ready_i,
  output logic                 dec_ready_o,
  output wr16_pkg::decoded_t   dec_o,
  output logic                 dec_valid_o,
  output wr16_pkg::reg_addr_t  rd_addr_o,
  output wr16_pkg::reg_addr_t  rn_addr_o
);

  import wr16_pkg::*;

  inst_t inst_q;
  logic  dec_valid_q;

  assign dec_ready_o = !dec_valid_q || ex_ready_i;
  assign dec_valid_o = dec_valid_q;

  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dec_valid_q <= 1'b0;
    end
    else if (dec_ready_o)
    begin
      dec_valid_q <= fetch_valid_i;
    end
  end

  always_ff @(posedge core_clk)
  begin
    if (dec_ready_o && fetch_valid_i)
    begin
      inst_q <= fetch_inst_i;
    end
  end

  // Register numbers go straight to the register file
  assign rd_addr_o = inst_q[11:8];
  assign rn_addr_o = inst_q[7:4];

  always_comb
  begin
    dec_o         = '0;
    dec_o.rd      = inst_q[11:8];
    dec_o.rn      = inst_q[7:4];
    dec_o.literal = inst_q[7:0];
    case (inst_q[15:12])
      `WR16_OP_LDI:
      begin
        dec_o.alu_op    = ALU_PASS_B;
        dec_o.use_lit   = 1'b1;
        dec_o.reg_write = 1'b1;
      end
      `WR16_OP_ADD: {dec_o.alu_op, dec_o.reg_write} = {ALU_ADD, 1'b1};
      `WR16_OP_SUB: {dec_o.alu_op, dec_o.reg_write} = {ALU_SUB, 1'b1};
      `WR16_OP_AND: {dec_o.alu_op, dec_o.reg_write} = {ALU_AND, 1'b1};
      `WR16_OP_OR:  {dec_o.alu_op, dec_o.reg_write} = {ALU_OR, 1'b1};
      `WR16_OP_XOR: {dec_o.alu_op, dec_o.reg_write} = {ALU_XOR, 1'b1};
      `WR16_OP_LD:
      begin
        dec_o.mem_read  = 1'b1;
        dec_o.reg_write = 1'b1;
      end
      `WR16_OP_ST:  dec_o.mem_write = 1'b1;
      default:      dec_o.reg_write = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/wr16_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wr16_cfg.svh"

module wr16_reg_file (
  input  wire                  core_clk,
  input  wire                  rst_n_i,
  input  wr16_pkg::reg_addr_t  rd_addr_i,
  input  wr16_pkg::reg_addr_t  rn_addr_i,
  input  wr16_pkg::reg_write_t commit_i,
  output wr16_pkg::word_t      rd_data_o,
  output wr16_pkg::word_t      rn_data_o
);

  import wr16_pkg::*;

  word_t regs_q [`WR16_NUM_REGS];

  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < `WR16_NUM_REGS; i++)
      begin
        regs_q[i] <= '0;
      end
    end
    else if (commit_i.en)
    begin
      regs_q[commit_i.addr] <= commit_i.data;
    end
  end

  // Reads see the array before this cycle's commit
  assign rd_data_o = regs_q[rd_addr_i];
  assign rn_data_o = regs_q[rn_addr_i];

endmodule

`default_nettype wire

/* verilog/wr16_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module wr16_execute (
  input  wire                  core_clk,
  input  wire                  rst_n_i,
  input  wr16_pkg::decoded_t   dec_i,
  input  wire                  dec_valid_i,
  input  wr16_pkg::word_t      rd_data_i,
  input  wr16_pkg::word_t      rn_data_i,
  input  wire                  mem_ready_i,
  input  wr16_pkg::reg_write_t commit_i,
  input  wr16_pkg::reg_write_t retired_i,
  output logic                 ex_ready_o,
  output wr16_pkg::mem_req_t   mem_req_o,
  output logic                 mem_req_valid_o
);

  import wr16_pkg::*;

  decoded_t dec_q;
  word_t    rd_q;
  word_t    rn_q;
  logic     ex_valid_q;
  word_t    op_rd;
  word_t    op_rn;
  word_t    op_b;
  word_t    alu_result;

  // Newest write wins, the captured copy may miss up to two commits
  function automatic word_t fwd_sel(reg_addr_t r, word_t captured,
                                    reg_write_t commit, reg_write_t retired);
    if (commit.en && commit.addr == r)
      return commit.data;
    else if (retired.en && retired.addr == r)
      return retired.data;
    else
      return captured;
  endfunction

  assign ex_ready_o      = !ex_valid_q || mem_ready_i;
  assign mem_req_valid_o = ex_valid_q;

  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ex_valid_q <= 1'b0;
    end
    else if (ex_ready_o)
    begin
      ex_valid_q <= dec_valid_i;
    end
  end

  always_ff @(posedge core_clk)
  begin
    if (ex_ready_o && dec_valid_i)
    begin
      dec_q <= dec_i;
      rd_q  <= rd_data_i;
      rn_q  <= rn_data_i;
    end
  end

  assign op_rd = fwd_sel(dec_q.rd, rd_q, commit_i, retired_i);
  assign op_rn = fwd_sel(dec_q.rn, rn_q, commit_i, retired_i);
  assign op_b  = dec_q.use_lit ? word_t'(dec_q.literal) : op_rn;

  always_comb
  begin
    case (dec_q.alu_op)
      ALU_ADD: alu_result = op_rd + op_b;
      ALU_SUB: alu_result = op_rd - op_b;
      ALU_AND: alu_result = op_rd & op_b;
      ALU_OR:  alu_result = op_rd | op_b;
      ALU_XOR: alu_result = op_rd ^ op_b;
      default: alu_result = op_b;
    endcase
  end

  always_comb
  begin
    mem_req_o.alu_result = alu_result;
    mem_req_o.store_data = op_rd;
    mem_req_o.addr       = addr_t'(op_rn);
    mem_req_o.mem_read   = dec_q.mem_read;
    mem_req_o.mem_write  = dec_q.mem_write;
    mem_req_o.reg_write  = dec_q.reg_write;
    mem_req_o.rd         = dec_q.rd;
  end

endmodule

`default_nettype wire

/* verilog/wr16_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module wr16_mem_stage (
  input  wire                  core_clk,
  input  wire                  rst_n_i,
  input  wr16_pkg::mem_req_t   mem_req_i,
  input  wire                  mem_req_valid_i,
  input  wr16_pkg::word_t      mem_data_i,
  input  wire                  mem_valid_i,
  output logic                 mem_ready_o,
  output wr16_pkg::addr_t      mem_addr_o,
  output wr16_pkg::word_t      mem_data_o,
  output logic                 mem_read_o,
  output logic                 mem_write_o,
  output logic                 mem_valid_o,
  output wr16_pkg::reg_write_t commit_o,
  output wr16_pkg::reg_write_t retired_o
);

  import wr16_pkg::*;

  mem_req_t   req_q;
  logic       valid_q;
  logic       is_access;
  logic       done;
  reg_write_t retired_q;

  assign is_access = req_q.mem_read || req_q.mem_write;

  // ALU results leave at once, accesses wait for the bus
  assign done        = valid_q && (!is_access || mem_valid_i);
  assign mem_ready_o = !valid_q || done;

  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      valid_q <= 1'b0;
    end
    else if (mem_ready_o)
    begin
      valid_q <= mem_req_valid_i;
    end
  end

  always_ff @(posedge core_clk)
  begin
    if (mem_ready_o && mem_req_valid_i)
    begin
      req_q <= mem_req_i;
    end
  end

  // Data port, held steady from entry until mem_valid_i
  assign mem_valid_o = valid_q && is_access;
  assign mem_read_o  = valid_q && req_q.mem_read;
  assign mem_write_o = valid_q && req_q.mem_write;
  assign mem_addr_o  = req_q.addr;
  assign mem_data_o  = req_q.store_data;

  always_comb
  begin
    commit_o.en   = done && req_q.reg_write;
    commit_o.addr = req_q.rd;
    commit_o.data = req_q.mem_read ? mem_data_i : req_q.alu_result;
  end

  // Last register write that reached the file
  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      retired_q <= '0;
    end
    else if (commit_o.en)
    begin
      retired_q <= commit_o;
    end
  end

  assign retired_o = retired_q;

endmodule

`default_nettype wire

/* verilog/wr16_core.sv */
`timescale 1ns/1ps
`default_nettype none

module wr16_core (
  input  wire             core_clk,
  input  wire             rst_n_i,
  // Instruction port
  output wr16_pkg::addr_t inst_addr_o,
  output logic            inst_valid_o,
  input  wr16_pkg::inst_t inst_data_i,
  input  wire             inst_valid_i,
  // Data port
  output wr16_pkg::addr_t mem_addr_o,
  output wr16_pkg::word_t mem_data_o,
  output logic            mem_read_o,
  output logic            mem_write_o,
  output logic            mem_valid_o,
  input  wr16_pkg::word_t mem_data_i,
  input  wire             mem_valid_i
);

  import wr16_pkg::*;

  inst_t      fetch_inst;
  logic       fetch_valid;
  logic       dec_ready;
  decoded_t   dec;
  logic       dec_valid;
  reg_addr_t  rd_addr;
  reg_addr_t  rn_addr;
  word_t      rd_data;
  word_t      rn_data;
  logic       ex_ready;
  mem_req_t   mem_req;
  logic       mem_req_valid;
  logic       mem_ready;
  reg_write_t commit;
  reg_write_t retired;

  wr16_fetch u_fetch (
    .core_clk      (core_clk),
    .rst_n_i       (rst_n_i),
    .inst_data_i   (inst_data_i),
    .inst_valid_i  (inst_valid_i),
    .dec_ready_i   (dec_ready),
    .inst_addr_o   (inst_addr_o),
    .inst_valid_o  (inst_valid_o),
    .fetch_inst_o  (fetch_inst),
    .fetch_valid_o (fetch_valid)
  );

  wr16_decode u_decode (
    .core_clk      (core_clk),
    .rst_n_i       (rst_n_i),
    .fetch_inst_i  (fetch_inst),
    .fetch_valid_i (fetch_valid),
    .ex_ready_i    (ex_ready),
    .dec_ready_o   (dec_ready),
    .dec_o         (dec),
    .dec_valid_o   (dec_valid),
    .rd_addr_o     (rd_addr),
    .rn_addr_o     (rn_addr)
  );

  wr16_reg_file u_reg_file (
    .core_clk  (core_clk),
    .rst_n_i   (rst_n_i),
    .rd_addr_i (rd_addr),
    .rn_addr_i (rn_addr),
    .commit_i  (commit),
    .rd_data_o (rd_data),
    .rn_data_o (rn_data)
  );

  wr16_execute u_execute (
    .core_clk        (core_clk),
    .rst_n_i         (rst_n_i),
    .dec_i           (dec),
    .dec_valid_i     (dec_valid),
    .rd_data_i       (rd_data),
    .rn_data_i       (rn_data),
    .mem_ready_i     (mem_ready),
    .commit_i        (commit),
    .retired_i       (retired),
    .ex_ready_o      (ex_ready),
    .mem_req_o       (mem_req),
    .mem_req_valid_o (mem_req_valid)
  );

  wr16_mem_stage u_mem_stage (
    .core_clk        (core_clk),
    .rst_n_i         (rst_n_i),
    .mem_req_i       (mem_req),
    .mem_req_valid_i (mem_req_valid),
    .mem_data_i      (mem_data_i),
    .mem_valid_i     (mem_valid_i),
    .mem_ready_o     (mem_ready),
    .mem_addr_o      (mem_addr_o),
    .mem_data_o      (mem_data_o),
    .mem_read_o      (mem_read_o),
    .mem_write_o     (mem_write_o),
    .mem_valid_o     (mem_valid_o),
    .commit_o        (commit),
    .retired_o       (retired)
  );

endmodule

`default_nettype wire

/* sim/wr16_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module wr16_chk (
  input wire                  core_clk,
  input wire                  rst_n_i,
  input wire wr16_pkg::addr_t inst_addr_i,
  input wire                  inst_req_i,
  input wire                  inst_ack_i,
  input wire wr16_pkg::addr_t mem_addr_i,
  input wire wr16_pkg::word_t mem_data_i,
  input wire                  mem_read_i,
  input wire                  mem_write_i,
  input wire                  mem_req_i,
  input wire                  mem_ack_i
);

  import wr16_pkg::*;

  int unsigned fail_count;
  addr_t       next_addr_q;

  initial
  begin
    fail_count = 0;
  end

  // Address the next instruction request must carry
  always_ff @(posedge core_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      next_addr_q <= '0;
    end
    else if (inst_req_i && inst_ack_i)
    begin
      next_addr_q <= inst_addr_i + 1'b1;
    end
  end

  // Ports quiet in reset and in the first cycle after release
  reset_quiet: assert property (@(posedge core_clk)
    (!rst_n_i || $rose(rst_n_i)) |-> !inst_req_i && !mem_req_i && !mem_read_i && !mem_write_i)
  else
  begin
    $error("Port control active during or right after reset");
    fail_count++;
  end

  inst_addr_order: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    inst_req_i |-> inst_addr_i == next_addr_q)
  else
  begin
    $error("Instruction address out of sequence");
    fail_count++;
  end

  inst_hold: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    inst_req_i && !inst_ack_i |=> inst_req_i && $stable(inst_addr_i))
  else
  begin
    $error("Instruction request dropped or changed before completion");
    fail_count++;
  end

  mem_one_kind: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    mem_req_i |-> mem_read_i != mem_write_i)
  else
  begin
    $error("Data request without exactly one of read or write");
    fail_count++;
  end

  // Everything on the data port frozen until the memory answers
  mem_hold: assert property (@(posedge core_clk) disable iff (!rst_n_i)
    mem_req_i && !mem_ack_i |=> mem_req_i && $stable(mem_addr_i) && $stable(mem_data_i)
      && $stable(mem_read_i) && $stable(mem_write_i))
  else
  begin
    $error("Data request dropped or changed before completion");
    fail_count++;
  end

endmodule

bind wr16_core wr16_chk u_chk (
  .core_clk    (core_clk),
  .rst_n_i     (rst_n_i),
  .inst_addr_i (inst_addr_o),
  .inst_req_i  (inst_valid_o),
  .inst_ack_i  (inst_valid_i),
  .mem_addr_i  (mem_addr_o),
  .mem_data_i  (mem_data_o),
  .mem_read_i  (mem_read_o),
  .mem_write_i (mem_write_o),
  .mem_req_i   (mem_valid_o),
  .mem_ack_i   (mem_valid_i)
);

`default_nettype wire

/* sim/wr16_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "wr16_cfg.svh"

module wr16_tb;

  import wr16_pkg::*;

  localparam int unsigned SEED = 32'ha2d9_b953;
  // Room for 48 words at about 10 cycles each with worst latencies, three times over
  localparam int unsigned MAX_CYCLES = 48 * 10 * 3 + 60;

  logic        core_clk;
  logic        rst_n_i;
  addr_t       inst_addr;
  logic        inst_req;
  inst_t       inst_data;
  logic        inst_ack;
  addr_t       mem_addr;
  word_t       mem_wdata;
  logic        mem_rd;
  logic        mem_wr;
  logic        mem_req;
  word_t       mem_rdata;
  logic        mem_ack;

  inst_t       prog [$];
  word_t       data_mem [word_t];
  addr_t       exp_addr [$];
  word_t       exp_data [$];
  logic        stores_done;

  wr16_core dut_i (
    .core_clk     (core_clk),
    .rst_n_i      (rst_n_i),
    .inst_addr_o  (inst_addr),
    .inst_valid_o (inst_req),
    .inst_data_i  (inst_data),
    .inst_valid_i (inst_ack),
    .mem_addr_o   (mem_addr),
    .mem_data_o   (mem_wdata),
    .mem_read_o   (mem_rd),
    .mem_write_o  (mem_wr),
    .mem_valid_o  (mem_req),
    .mem_data_i   (mem_rdata),
    .mem_valid_i  (mem_ack)
  );

  function automatic inst_t rr_word(logic [3:0] op, int rd, int rn);
    return {op, 4'(rd), 4'(rn), 4'h0};
  endfunction

  function automatic inst_t ldi_word(int rd, logic [7:0] lit);
    return {`WR16_OP_LDI, 4'(rd), lit};
  endfunction

  // Contents of locations never stored to
  function automatic word_t mem_fill(addr_t a);
    return (a * 32'h9e37_79b9) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "Run stopped on error");
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    assert (actual === expected)
    else
    begin
      $display("Fail at %0t ns: %s expected 0x%08h, got 0x%08h",
               $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic build_program();
    prog.push_back(ldi_word(1, 8'h12));
    prog.push_back(ldi_word(2, 8'h34));
    // Back-to-back dependent ALU chain
    prog.push_back(rr_word(`WR16_OP_ADD, 1, 2));
    prog.push_back(rr_word(`WR16_OP_SUB, 1, 2));
    prog.push_back(rr_word(`WR16_OP_XOR, 1, 2));
    prog.push_back(ldi_word(3, 8'h40));
    prog.push_back(rr_word(`WR16_OP_ST, 1, 3));
    prog.push_back(rr_word(`WR16_OP_OR, 2, 1));
    prog.push_back(rr_word(`WR16_OP_AND, 2, 3));
    prog.push_back(ldi_word(4, 8'h41));
    prog.push_back(rr_word(`WR16_OP_ST, 2, 4));
    prog.push_back(ldi_word(5, 8'h07));
    prog.push_back(ldi_word(5, 8'h09));
    prog.push_back(rr_word(`WR16_OP_ADD, 5, 5));
    prog.push_back(rr_word(`WR16_OP_ADD, 5, 1));
    prog.push_back(rr_word(`WR16_OP_ST, 5, 3));
    // Read back a stored word and use it at once
    prog.push_back(rr_word(`WR16_OP_LD, 6, 3));
    prog.push_back(rr_word(`WR16_OP_ADD, 6, 6));
    prog.push_back(rr_word(`WR16_OP_ST, 6, 4));
    prog.push_back(ldi_word(7, 8'h80));
    prog.push_back(rr_word(`WR16_OP_LD, 8, 7));
    prog.push_back(rr_word(`WR16_OP_ST, 8, 4));
    prog.push_back(rr_word(`WR16_OP_LD, 9, 7));
    prog.push_back(rr_word(`WR16_OP_XOR, 9, 5));
    prog.push_back(rr_word(`WR16_OP_SUB, 9, 1));
    prog.push_back(ldi_word(10, 8'h42));
    prog.push_back(rr_word(`WR16_OP_ST, 9, 10));
    prog.push_back(rr_word(`WR16_OP_LD, 11, 10));
    prog.push_back(rr_word(`WR16_OP_OR, 11, 2));
    prog.push_back(rr_word(`WR16_OP_AND, 11, 9));
    prog.push_back(rr_word(`WR16_OP_ST, 11, 7));
    prog.push_back(rr_word(`WR16_OP_LD, 12, 7));
    prog.push_back(rr_word(`WR16_OP_ST, 12, 3));
    prog.push_back(ldi_word(13, 8'hff));
    prog.push_back(rr_word(`WR16_OP_SUB, 13, 12));
    prog.push_back(ldi_word(14, 8'h44));
    prog.push_back(rr_word(`WR16_OP_ST, 13, 14));
    // Unused opcode runs as NOP
    prog.push_back(16'hc123);
    prog.push_back(rr_word(`WR16_OP_XOR, 1, 1));
    prog.push_back(ldi_word(15, 8'h45));
    prog.push_back(rr_word(`WR16_OP_ST, 1, 15));
  endtask

  // Steps the program in order to get the expected stores
  task automatic run_reference();
    word_t regs [16];
    word_t ref_mem [word_t];
    inst_t w;
    int    rd;
    int    rn;
    for (int i = 0; i < 16; i++)
    begin
      regs[i] = '0;
    end
    foreach (prog[i])
    begin
      w  = prog[i];
      rd = w[11:8];
      rn = w[7:4];
      case (w[15:12])
        `WR16_OP_LDI: regs[rd] = {24'h0, w[7:0]};
        `WR16_OP_ADD: regs[rd] = regs[rd] + regs[rn];
        `WR16_OP_SUB: regs[rd] = regs[rd] - regs[rn];
        `WR16_OP_AND: regs[rd] = regs[rd] & regs[rn];
        `WR16_OP_OR:  regs[rd] = regs[rd] | regs[rn];
        `WR16_OP_XOR: regs[rd] = regs[rd] ^ regs[rn];
        `WR16_OP_LD:
        begin
          regs[rd] = ref_mem.exists(regs[rn]) ? ref_mem[regs[rn]] : mem_fill(regs[rn]);
        end
        `WR16_OP_ST:
        begin
          exp_addr.push_back(regs[rn]);
          exp_data.push_back(regs[rd]);
          ref_mem[regs[rn]] = regs[rd];
        end
        default: ;
      endcase
    end
  endtask

  initial
  begin
    core_clk = 1'b0;
    forever #10 core_clk = ~core_clk;
  end

  // Instruction memory, answers after 0 to 3 extra cycles
  initial
  begin : inst_port
    int    lat;
    addr_t exp_pc;
    lat       = -1;
    exp_pc    = '0;
    inst_ack  = 1'b0;
    inst_data = '0;
    forever
    begin
      @(negedge core_clk);
      if (!rst_n_i || inst_ack)
      begin
        inst_ack = 1'b0;
        lat      = -1;
      end
      else if (inst_req)
      begin
        if (lat < 0)
          lat = $urandom_range(3, 0);
        if (lat == 0)
        begin
          check_word("inst_addr_o", exp_pc, inst_addr);
          inst_data = (inst_addr < prog.size()) ? prog[inst_addr] : '0;
          inst_ack  = 1'b1;
          exp_pc++;
        end
        else
        begin
          lat--;
        end
      end
    end
  end

  // Data memory with the same latency range
  initial
  begin : data_port
    int lat;
    lat       = -1;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    forever
    begin
      @(negedge core_clk);
      if (!rst_n_i || mem_ack)
      begin
        mem_ack = 1'b0;
        lat     = -1;
      end
      else if (mem_req)
      begin
        if (lat < 0)
          lat = $urandom_range(3, 0);
        if (lat > 0)
        begin
          lat--;
        end
        else if (mem_wr)
        begin
          assert (exp_addr.size() > 0)
          else
          begin
            $display("Error at %0t ns: store issued after the last expected one", $time);
            abort_run();
          end
          check_word("mem_addr_o", exp_addr.pop_front(), mem_addr);
          check_word("mem_data_o", exp_data.pop_front(), mem_wdata);
          data_mem[mem_addr] = mem_wdata;
          mem_ack = 1'b1;
          if (exp_addr.size() == 0)
            stores_done = 1'b1;
        end
        else
        begin
          mem_rdata = data_mem.exists(mem_addr) ? data_mem[mem_addr] : mem_fill(mem_addr);
          mem_ack   = 1'b1;
        end
      end
    end
  end

  initial
  begin : watchdog
    int unsigned cycles;
    cycles = 0;
    forever
    begin
      @(posedge core_clk);
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
        $display("Error: run hit the %0d cycle limit with %0d stores outstanding",
                 MAX_CYCLES, exp_addr.size());
        abort_run();
      end
      if (dut_i.u_chk.fail_count != 0)
      begin
        $display("Error at %0t ns: a port protocol assertion failed", $time);
        abort_run();
      end
    end
  end

  initial
  begin : main_seq
    void'($urandom(SEED));
    rst_n_i     = 1'b0;
    stores_done = 1'b0;
    build_program();
    run_reference();
    repeat (5) @(posedge core_clk);
    @(negedge core_clk);
    rst_n_i = 1'b1;
    wait (stores_done);
    repeat (2) @(posedge core_clk);
    if (dut_i.u_chk.fail_count == 0)
    begin
      $display("** PASS **");
      $finish;
    end
    else
    begin
      $display("** FAIL **");
      $fatal(1, "Port protocol errors seen");
    end
  end

endmodule

`default_nettype wire

/* wr16_core.f */
+incdir+verilog
verilog/wr16_pkg.sv
verilog/wr16_fetch.sv
verilog/wr16_decode.sv
verilog/wr16_reg_file.sv
verilog/wr16_execute.sv
verilog/wr16_mem_stage.sv
verilog/wr16_core.sv
sim/wr16_chk.sv
sim/wr16_tb.sv
